/* common/issue_pkg.sv */
// shared types for the three-row issue stage
// a source tag of k waits on the unit whose fu_e value is k-1, zero means ready
`default_nettype none

package issue_pkg;

    // one status row per functional unit
    localparam int NUM_FU = 3;

    // functional units, the value doubles as the table row index
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LDST   = 2'd1,
        FU_BRANCH = 2'd2
    } fu_e;

    // source tag naming the producing unit
    typedef logic [1:0] tag_t;

    localparam tag_t TAG_READY = 2'd0;

    // row states
    typedef enum logic [1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_RDY   = 2'd2,
        FUST_EX    = 2'd3
    } fust_state_e;

    // opcodes carried through the table to the units
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_LW  = 3'd4,
        OP_SW  = 3'd5,
        OP_BEQ = 3'd6,
        OP_BNE = 3'd7
    } op_e;

    // architectural register index
    typedef logic [4:0] regsel_t;

    // tag that operands waiting on a unit carry
    function automatic tag_t fu_to_tag(fu_e fu);
        tag_t fu_tag;
        fu_tag = tag_t'(fu);
        return fu_tag + tag_t'(1);
    endfunction

endpackage

`default_nettype wire

/* issue/age_tracker.sv */
// saturating age per row, only the relative order between rows matters
// assumes at most one load strobe per cycle
`timescale 1ns/1ps
`default_nettype none

module age_tracker #(
    parameter int AGE_WIDTH = 3
) (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic [issue_pkg::NUM_FU-1:0]                load,
    input  logic [issue_pkg::NUM_FU-1:0]                clr_age,
    output logic [issue_pkg::NUM_FU-1:0][AGE_WIDTH-1:0] age
);
    import issue_pkg::*;

    localparam logic [AGE_WIDTH-1:0] AGE_MAX = '1;

    logic                              any_load;
    logic [NUM_FU-1:0][AGE_WIDTH-1:0]  next_age;

    assign any_load = |load;

    always_comb begin
        next_age = age;
        for (int i = 0; i < NUM_FU; i++) begin
            if (load[i]) begin
                // newest instruction starts at one
                next_age[i] = AGE_WIDTH'(1);
            end else if (clr_age[i]) begin
                next_age[i] = '0;
            end else if (any_load && age[i] != AGE_MAX) begin
                // some other row took a new instruction, so this one got older
                next_age[i] = age[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            age <= '0;
        end else begin
            age <= next_age;
        end
    end

endmodule

`default_nettype wire

/* issue/fust_sequencer.sv */
// per-row FSM and oldest-ready selection, at most one row issues per cycle
// a flush drops WAIT and RDY rows, rows already in EX wait for their writeback
`timescale 1ns/1ps
`default_nettype none

module fust_sequencer #(
    parameter int AGE_WIDTH = 3
) (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic                                        disp_en,
    input  issue_pkg::fu_e                              disp_fu,
    input  logic                                        wb_en,
    input  issue_pkg::fu_e                              wb_fu,
    input  logic                                        freeze,
    input  logic                                        flush,
    input  logic [issue_pkg::NUM_FU-1:0]                operands_clear,
    input  logic [issue_pkg::NUM_FU-1:0][AGE_WIDTH-1:0] age,
    output logic [issue_pkg::NUM_FU-1:0]                load,
    output logic [issue_pkg::NUM_FU-1:0]                clr_age,
    output logic [issue_pkg::NUM_FU-1:0]                fust_busy,
    output logic [issue_pkg::NUM_FU-1:0]                issue_sel,
    output logic                                        issue_go
);
    import issue_pkg::*;

    fust_state_e            state      [NUM_FU];
    fust_state_e            next_state [NUM_FU];
    logic [NUM_FU-1:0]      rdy;
    logic                   found;
    logic [AGE_WIDTH-1:0]   best_age;

    // a dispatch lands only in an empty row of its own unit
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            load[i] = disp_en && !flush && (disp_fu == fu_e'(i))
                      && (state[i] == FUST_EMPTY);
        end
    end

    // oldest ready row wins, strict compare keeps ties on the lowest unit
    always_comb begin
        issue_sel = '0;
        found     = 1'b0;
        best_age  = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            rdy[i] = (state[i] == FUST_RDY);
        end
        if (!freeze && !flush) begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (rdy[i] && (!found || age[i] > best_age)) begin
                    issue_sel    = '0;
                    issue_sel[i] = 1'b1;
                    found        = 1'b1;
                    best_age     = age[i];
                end
            end
        end
    end

    assign issue_go = |issue_sel;

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            next_state[i] = state[i];
            case (state[i])
                FUST_EMPTY: begin
                    if (load[i]) next_state[i] = FUST_WAIT;
                end
                FUST_WAIT: begin
                    if (flush) next_state[i] = FUST_EMPTY;
                    else if (operands_clear[i]) next_state[i] = FUST_RDY;
                end
                FUST_RDY: begin
                    if (flush) next_state[i] = FUST_EMPTY;
                    else if (issue_sel[i]) next_state[i] = FUST_EX;
                end
                FUST_EX: begin
                    // unit reports completion through its writeback
                    if (wb_en && wb_fu == fu_e'(i)) next_state[i] = FUST_EMPTY;
                end
                default: next_state[i] = FUST_EMPTY;
            endcase
            clr_age[i]   = (next_state[i] == FUST_EX) || (next_state[i] == FUST_EMPTY);
            fust_busy[i] = (state[i] != FUST_EMPTY);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_FU; i++) begin
                state[i] <= FUST_EMPTY;
            end
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                state[i] <= next_state[i];
            end
        end
    end

endmodule

`default_nettype wire

/* issue/fust_table.sv */
// one instruction row per functional unit, written only on a load strobe
// issue_sel must be one-hot or zero, the read mux has no priority meaning
`timescale 1ns/1ps
`default_nettype none

module fust_table #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic [issue_pkg::NUM_FU-1:0]    load,
    input  issue_pkg::op_e                  disp_op,
    input  issue_pkg::regsel_t              disp_rd,
    input  issue_pkg::regsel_t              disp_rs1,
    input  issue_pkg::regsel_t              disp_rs2,
    input  logic [DATA_WIDTH-1:0]           disp_imm,
    input  logic                            disp_i_type,
    input  issue_pkg::tag_t                 disp_t1,
    input  issue_pkg::tag_t                 disp_t2,
    input  logic                            wb_en,
    input  issue_pkg::fu_e                  wb_fu,
    input  logic [issue_pkg::NUM_FU-1:0]    issue_sel,
    output logic [issue_pkg::NUM_FU-1:0]    operands_clear,
    output issue_pkg::op_e                  sel_op,
    output issue_pkg::regsel_t              sel_rd,
    output issue_pkg::regsel_t              sel_rs1,
    output issue_pkg::regsel_t              sel_rs2,
    output logic [DATA_WIDTH-1:0]           sel_imm,
    output logic                            sel_i_type
);
    import issue_pkg::*;

    op_e                   row_op     [NUM_FU];
    regsel_t               row_rd     [NUM_FU];
    regsel_t               row_rs1    [NUM_FU];
    regsel_t               row_rs2    [NUM_FU];
    logic [DATA_WIDTH-1:0] row_imm    [NUM_FU];
    logic                  row_i_type [NUM_FU];
    tag_t                  row_t1     [NUM_FU];
    tag_t                  row_t2     [NUM_FU];
    tag_t                  wb_tag;
    tag_t                  load_t1;
    tag_t                  load_t2;

    assign wb_tag = fu_to_tag(wb_fu);

    // a producer writing back right now already satisfies the incoming tag
    assign load_t1 = (wb_en && disp_t1 == wb_tag) ? TAG_READY : disp_t1;
    assign load_t2 = (wb_en && disp_t2 == wb_tag) ? TAG_READY : disp_t2;

    always_ff @(posedge CLK) begin
        for (int i = 0; i < NUM_FU; i++) begin
            if (load[i]) begin
                row_op[i]     <= disp_op;
                row_rd[i]     <= disp_rd;
                row_rs1[i]    <= disp_rs1;
                row_rs2[i]    <= disp_rs2;
                row_imm[i]    <= disp_imm;
                row_i_type[i] <= disp_i_type;
            end
        end
    end

    // tags clear on a matching writeback
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_FU; i++) begin
                row_t1[i] <= TAG_READY;
                row_t2[i] <= TAG_READY;
            end
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (load[i]) begin
                    row_t1[i] <= load_t1;
                    row_t2[i] <= load_t2;
                end else if (wb_en) begin
                    if (row_t1[i] == wb_tag) row_t1[i] <= TAG_READY;
                    if (row_t2[i] == wb_tag) row_t2[i] <= TAG_READY;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            operands_clear[i] = (row_t1[i] == TAG_READY) && (row_t2[i] == TAG_READY);
        end
    end

    // one-hot read mux toward the operand latch and register file
    always_comb begin
        sel_op     = OP_ADD;
        sel_rd     = '0;
        sel_rs1    = '0;
        sel_rs2    = '0;
        sel_imm    = '0;
        sel_i_type = 1'b0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (issue_sel[i]) begin
                sel_op     = row_op[i];
                sel_rd     = row_rd[i];
                sel_rs1    = row_rs1[i];
                sel_rs2    = row_rs2[i];
                sel_imm    = row_imm[i];
                sel_i_type = row_i_type[i];
            end
        end
    end

endmodule

`default_nettype wire

/* issue/issue_stage.sv */
// issue stage top, one FUST row each for ALU, load/store and branch
// dispatch to issue takes two cycles with no dependence and no contention
`timescale 1ns/1ps
`default_nettype none

module issue_stage #(
    parameter int DATA_WIDTH = 32,
    parameter int AGE_WIDTH  = 3
) (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            disp_en,
    input  issue_pkg::fu_e                  disp_fu,
    input  issue_pkg::op_e                  disp_op,
    input  issue_pkg::regsel_t              disp_rd,
    input  issue_pkg::regsel_t              disp_rs1,
    input  issue_pkg::regsel_t              disp_rs2,
    input  logic [DATA_WIDTH-1:0]           disp_imm,
    input  logic                            disp_i_type,
    input  issue_pkg::tag_t                 disp_t1,
    input  issue_pkg::tag_t                 disp_t2,
    input  logic                            wb_en,
    input  issue_pkg::fu_e                  wb_fu,
    input  issue_pkg::regsel_t              wb_rd,
    input  logic [DATA_WIDTH-1:0]           wb_data,
    input  logic                            freeze,
    input  logic                            flush,
    output logic [issue_pkg::NUM_FU-1:0]    fust_busy,
    output logic [issue_pkg::NUM_FU-1:0]    iss_fu_en,
    output issue_pkg::op_e                  iss_op,
    output issue_pkg::regsel_t              iss_rd,
    output logic [DATA_WIDTH-1:0]           iss_imm,
    output logic [DATA_WIDTH-1:0]           iss_rdat1,
    output logic [DATA_WIDTH-1:0]           iss_rdat2
);
    import issue_pkg::*;

    logic [NUM_FU-1:0]                  load;
    logic [NUM_FU-1:0]                  clr_age;
    logic [NUM_FU-1:0]                  operands_clear;
    logic [NUM_FU-1:0]                  issue_sel;
    logic                               issue_go;
    logic [NUM_FU-1:0][AGE_WIDTH-1:0]   age;
    op_e                                sel_op;
    regsel_t                            sel_rd;
    regsel_t                            sel_rs1;
    regsel_t                            sel_rs2;
    logic [DATA_WIDTH-1:0]              sel_imm;
    logic                               sel_i_type;
    logic [DATA_WIDTH-1:0]              rdat1;
    logic [DATA_WIDTH-1:0]              rdat2;

    // writeback owns the write port, the selected row drives the reads
    regfile #(.DATA_WIDTH(DATA_WIDTH)) u_regfile (
        .CLK(CLK), .nRST(nRST), .wen(wb_en), .wsel(wb_rd), .wdata(wb_data),
        .rsel1(sel_rs1), .rsel2(sel_rs2), .rdat1(rdat1), .rdat2(rdat2)
    );

    fust_table #(.DATA_WIDTH(DATA_WIDTH)) u_fust_table (
        .CLK(CLK), .nRST(nRST), .load(load), .disp_op(disp_op), .disp_rd(disp_rd),
        .disp_rs1(disp_rs1), .disp_rs2(disp_rs2), .disp_imm(disp_imm),
        .disp_i_type(disp_i_type), .disp_t1(disp_t1), .disp_t2(disp_t2),
        .wb_en(wb_en), .wb_fu(wb_fu), .issue_sel(issue_sel),
        .operands_clear(operands_clear), .sel_op(sel_op), .sel_rd(sel_rd),
        .sel_rs1(sel_rs1), .sel_rs2(sel_rs2), .sel_imm(sel_imm), .sel_i_type(sel_i_type)
    );

    age_tracker #(.AGE_WIDTH(AGE_WIDTH)) u_age_tracker (
        .CLK(CLK), .nRST(nRST), .load(load), .clr_age(clr_age), .age(age)
    );

    fust_sequencer #(.AGE_WIDTH(AGE_WIDTH)) u_fust_sequencer (
        .CLK(CLK), .nRST(nRST), .disp_en(disp_en), .disp_fu(disp_fu),
        .wb_en(wb_en), .wb_fu(wb_fu), .freeze(freeze), .flush(flush),
        .operands_clear(operands_clear), .age(age), .load(load), .clr_age(clr_age),
        .fust_busy(fust_busy), .issue_sel(issue_sel), .issue_go(issue_go)
    );

    operand_latch #(.DATA_WIDTH(DATA_WIDTH)) u_operand_latch (
        .CLK(CLK), .nRST(nRST), .issue_go(issue_go), .issue_sel(issue_sel),
        .freeze(freeze), .sel_op(sel_op), .sel_rd(sel_rd), .sel_imm(sel_imm),
        .sel_i_type(sel_i_type), .rdat1(rdat1), .rdat2(rdat2), .iss_fu_en(iss_fu_en),
        .iss_op(iss_op), .iss_rd(iss_rd), .iss_imm(iss_imm), .iss_rdat1(iss_rdat1),
        .iss_rdat2(iss_rdat2)
    );

endmodule

`default_nettype wire

/* issue/operand_latch.sv */
// issue output register, operand 2 takes the immediate for i-type ops
// freeze holds the whole packet, including the unit enables
`timescale 1ns/1ps
`default_nettype none

module operand_latch #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            issue_go,
    input  logic [issue_pkg::NUM_FU-1:0]    issue_sel,
    input  logic                            freeze,
    input  issue_pkg::op_e                  sel_op,
    input  issue_pkg::regsel_t              sel_rd,
    input  logic [DATA_WIDTH-1:0]           sel_imm,
    input  logic                            sel_i_type,
    input  logic [DATA_WIDTH-1:0]           rdat1,
    input  logic [DATA_WIDTH-1:0]           rdat2,
    output logic [issue_pkg::NUM_FU-1:0]    iss_fu_en,
    output issue_pkg::op_e                  iss_op,
    output issue_pkg::regsel_t              iss_rd,
    output logic [DATA_WIDTH-1:0]           iss_imm,
    output logic [DATA_WIDTH-1:0]           iss_rdat1,
    output logic [DATA_WIDTH-1:0]           iss_rdat2
);

    logic [DATA_WIDTH-1:0] operand2;
    logic                  capture;

    assign operand2 = sel_i_type ? sel_imm : rdat2;
    assign capture  = issue_go && !freeze;

    // enables last one cycle unless frozen
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            iss_fu_en <= '0;
        end else if (!freeze) begin
            iss_fu_en <= issue_go ? issue_sel : '0;
        end
    end

    // payload only changes on a real issue
    always_ff @(posedge CLK) begin
        if (capture) begin
            iss_op    <= sel_op;
            iss_rd    <= sel_rd;
            iss_imm   <= sel_imm;
            iss_rdat1 <= rdat1;
            iss_rdat2 <= operand2;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds the issue stage testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module issue_tb -f verilog.f -o issue_sim \
    && ./obj_dir/issue_sim > sim.log 2>&1 \
    || { echo "build or simulation run did not complete"; exit 1; }
cat sim.log
grep -qx 'sim passed' sim.log && exit 0 || exit 1

/* src/regfile.sv */
// 32 x DATA_WIDTH register file, register zero is hardwired to zero
// reads are combinational and do not bypass a write in the same cycle
`timescale 1ns/1ps
`default_nettype none

module regfile #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    wen,
    input  issue_pkg::regsel_t      wsel,
    input  logic [DATA_WIDTH-1:0]   wdata,
    input  issue_pkg::regsel_t      rsel1,
    input  issue_pkg::regsel_t      rsel2,
    output logic [DATA_WIDTH-1:0]   rdat1,
    output logic [DATA_WIDTH-1:0]   rdat2
);

    logic [DATA_WIDTH-1:0] regs [32];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            // writes to register zero are dropped
            regs[wsel] <= wdata;
        end
    end

    // register zero always reads back as zero
    assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
    assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

`default_nettype wire

/* test/issue_tb.sv */
// directed testbench for the issue stage with a register file model
// inputs change 1 ns after the rising edge and outputs are checked at that point
`timescale 1ns/1ps
`default_nettype none

module issue_tb;
    import issue_pkg::*;

    localparam int DATA_WIDTH = 32;
    localparam int AGE_WIDTH  = 3;
    // the tests take about 110 cycles
    localparam int TIMEOUT_CYCLES = 400;
    localparam int ISSUE_WAIT     = 20;

    // tag k waits on the unit with fu_e value k-1
    localparam tag_t TAG_NONE    = 2'd0;
    localparam tag_t TAG_ON_ALU  = 2'd1;
    localparam tag_t TAG_ON_LDST = 2'd2;

    logic                  CLK;
    logic                  nRST;
    logic                  disp_en;
    fu_e                   disp_fu;
    op_e                   disp_op;
    regsel_t               disp_rd;
    regsel_t               disp_rs1;
    regsel_t               disp_rs2;
    logic [DATA_WIDTH-1:0] disp_imm;
    logic                  disp_i_type;
    tag_t                  disp_t1;
    tag_t                  disp_t2;
    logic                  wb_en;
    fu_e                   wb_fu;
    regsel_t               wb_rd;
    logic [DATA_WIDTH-1:0] wb_data;
    logic                  freeze;
    logic                  flush;
    logic [NUM_FU-1:0]     fust_busy;
    logic [NUM_FU-1:0]     iss_fu_en;
    op_e                   iss_op;
    regsel_t               iss_rd;
    logic [DATA_WIDTH-1:0] iss_imm;
    logic [DATA_WIDTH-1:0] iss_rdat1;
    logic [DATA_WIDTH-1:0] iss_rdat2;

    logic [DATA_WIDTH-1:0] model_regs [32];
    logic [31:0]           lfsr_state;
    int                    errors;
    int                    checks;
    int                    cycle_count;

    issue_stage #(.DATA_WIDTH(DATA_WIDTH), .AGE_WIDTH(AGE_WIDTH)) dut (
        .CLK(CLK), .nRST(nRST), .disp_en(disp_en), .disp_fu(disp_fu), .disp_op(disp_op),
        .disp_rd(disp_rd), .disp_rs1(disp_rs1), .disp_rs2(disp_rs2), .disp_imm(disp_imm),
        .disp_i_type(disp_i_type), .disp_t1(disp_t1), .disp_t2(disp_t2),
        .wb_en(wb_en), .wb_fu(wb_fu), .wb_rd(wb_rd), .wb_data(wb_data),
        .freeze(freeze), .flush(flush), .fust_busy(fust_busy), .iss_fu_en(iss_fu_en),
        .iss_op(iss_op), .iss_rd(iss_rd), .iss_imm(iss_imm), .iss_rdat1(iss_rdat1),
        .iss_rdat2(iss_rdat2)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not end within %0d cycles, %0d errors so far",
                     TIMEOUT_CYCLES, errors);
            $display("sim failed");
            $finish;
        end
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 32'h8020_0003;
        end
        return shifted;
    endfunction

    // one lfsr step for every bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_reg(input string name, input regsel_t expected, input regsel_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected r%0d actual r%0d", name, expected, actual);
        end
    endtask

    task automatic check_op(input string name, input op_e expected, input op_e actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %s actual %s (%0d)", name, expected.name(),
                     actual.name(), actual);
        end
    endtask

    task automatic check_fu_en(input string name, input logic [NUM_FU-1:0] expected,
                               input logic [NUM_FU-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic tick();
        @(posedge CLK);
        #1;
    endtask

    task automatic dispatch(input fu_e fu, input op_e op, input regsel_t rd,
                            input regsel_t rs1, input regsel_t rs2,
                            input logic [DATA_WIDTH-1:0] imm, input logic i_type,
                            input tag_t t1, input tag_t t2);
        disp_en     = 1'b1;
        disp_fu     = fu;
        disp_op     = op;
        disp_rd     = rd;
        disp_rs1    = rs1;
        disp_rs2    = rs2;
        disp_imm    = imm;
        disp_i_type = i_type;
        disp_t1     = t1;
        disp_t2     = t2;
        tick();
        disp_en = 1'b0;
    endtask

    // also keeps the register model current, register zero stays zero
    task automatic writeback(input fu_e fu, input regsel_t rd,
                             input logic [DATA_WIDTH-1:0] data);
        wb_en   = 1'b1;
        wb_fu   = fu;
        wb_rd   = rd;
        wb_data = data;
        if (rd != '0) begin
            model_regs[rd] = data;
        end
        tick();
        wb_en = 1'b0;
    endtask

    task automatic wait_issue(input string name, input logic [NUM_FU-1:0] expected);
        int waited;
        waited = 0;
        tick();
        while (iss_fu_en == '0 && waited < ISSUE_WAIT) begin
            tick();
            waited++;
        end
        if (iss_fu_en == '0) begin
            errors++;
            $display("%s: nothing was issued within %0d cycles", name, ISSUE_WAIT);
        end else begin
            check_fu_en(name, expected, iss_fu_en);
        end
    endtask

    task automatic test_reset();
        check_fu_en("reset busy", '0, fust_busy);
        check_fu_en("reset fu_en", '0, iss_fu_en);
        writeback(FU_ALU, 5'd0, 32'hdead_beef);
        writeback(FU_ALU, 5'd5, 32'h1234_5678);
        dispatch(FU_ALU, OP_ADD, 5'd7, 5'd0, 5'd5, '0, 1'b0, TAG_NONE, TAG_NONE);
        wait_issue("reset issue", 3'b001);
        check_word("reset rdat1", '0, iss_rdat1);
        check_word("reset rdat2", 32'h1234_5678, iss_rdat2);
        writeback(FU_ALU, 5'd7, 32'h0000_0777);
    endtask

    task automatic test_immediate();
        logic [DATA_WIDTH-1:0] imm;
        imm = 32'h0000_0abc;
        dispatch(FU_ALU, OP_ADD, 5'd9, 5'd5, 5'd3, imm, 1'b1, TAG_NONE, TAG_NONE);
        tick();
        check_fu_en("imm cycle one", '0, iss_fu_en);
        tick();
        check_fu_en("imm issue", 3'b001, iss_fu_en);
        check_op("imm op", OP_ADD, iss_op);
        check_reg("imm rd", 5'd9, iss_rd);
        check_word("imm imm", imm, iss_imm);
        check_word("imm rdat1", model_regs[5], iss_rdat1);
        check_word("imm rdat2", imm, iss_rdat2);
        tick();
        check_fu_en("imm pulse end", '0, iss_fu_en);
        writeback(FU_ALU, 5'd9, 32'h0000_1000);
    endtask

    task automatic test_dependence();
        logic [DATA_WIDTH-1:0] alu_result;
        alu_result = 32'h0bad_f00d;
        dispatch(FU_ALU, OP_SUB, 5'd10, 5'd5, 5'd9, '0, 1'b0, TAG_NONE, TAG_NONE);
        dispatch(FU_LDST, OP_LW, 5'd11, 5'd10, 5'd0, 32'h10, 1'b1, TAG_ON_ALU, TAG_NONE);
        wait_issue("dep alu issue", 3'b001);
        repeat (3) begin
            tick();
            check_fu_en("dep load held", '0, iss_fu_en);
        end
        check_fu_en("dep busy before wb", 3'b011, fust_busy);
        writeback(FU_ALU, 5'd10, alu_result);
        check_fu_en("dep busy after wb", 3'b010, fust_busy);
        tick();
        check_fu_en("dep wb plus one", '0, iss_fu_en);
        tick();
        check_fu_en("dep load issue", 3'b010, iss_fu_en);
        check_op("dep op", OP_LW, iss_op);
        check_word("dep rdat1", alu_result, iss_rdat1);
        check_word("dep rdat2", 32'h10, iss_rdat2);
        writeback(FU_LDST, 5'd11, 32'h0000_5555);
    endtask

    // both rows wait on the ALU, the one dispatched first must issue first
    task automatic test_oldest(input string name, input fu_e first, input op_e first_op,
                               input fu_e second, input op_e second_op);
        logic [NUM_FU-1:0] first_mask;
        logic [NUM_FU-1:0] second_mask;
        first_mask          = '0;
        first_mask[first]   = 1'b1;
        second_mask         = '0;
        second_mask[second] = 1'b1;
        dispatch(first, first_op, 5'd12, 5'd5, 5'd10, '0, 1'b0, TAG_ON_ALU, TAG_NONE);
        dispatch(second, second_op, 5'd13, 5'd10, 5'd5, '0, 1'b0, TAG_NONE, TAG_ON_ALU);
        writeback(FU_ALU, 5'd14, 32'h0000_00aa);
        tick();
        check_fu_en({name, " wb plus one"}, '0, iss_fu_en);
        tick();
        check_fu_en({name, " first"}, first_mask, iss_fu_en);
        check_op({name, " first op"}, first_op, iss_op);
        check_reg({name, " first rd"}, 5'd12, iss_rd);
        tick();
        check_fu_en({name, " second"}, second_mask, iss_fu_en);
        check_op({name, " second op"}, second_op, iss_op);
        check_reg({name, " second rd"}, 5'd13, iss_rd);
        writeback(first, 5'd12, 32'h0000_0c0c);
        writeback(second, 5'd13, 32'h0000_0d0d);
    endtask

    task automatic test_freeze();
        dispatch(FU_ALU, OP_OR, 5'd15, 5'd10, 5'd5, '0, 1'b0, TAG_NONE, TAG_NONE);
        dispatch(FU_LDST, OP_LW, 5'd16, 5'd12, 5'd0, 32'h20, 1'b1, TAG_NONE, TAG_NONE);
        wait_issue("freeze alu issue", 3'b001);
        freeze = 1'b1;
        repeat (3) begin
            tick();
            check_fu_en("freeze hold fu_en", 3'b001, iss_fu_en);
            check_op("freeze hold op", OP_OR, iss_op);
            check_reg("freeze hold rd", 5'd15, iss_rd);
            check_word("freeze hold imm", '0, iss_imm);
            check_word("freeze hold rdat1", model_regs[10], iss_rdat1);
            check_word("freeze hold rdat2", model_regs[5], iss_rdat2);
        end
        freeze = 1'b0;
        tick();
        check_fu_en("freeze release", 3'b010, iss_fu_en);
        check_reg("freeze release rd", 5'd16, iss_rd);
        check_word("freeze release rdat1", model_regs[12], iss_rdat1);
        check_word("freeze release rdat2", 32'h20, iss_rdat2);
        writeback(FU_ALU, 5'd15, 32'h0000_0f0f);
        writeback(FU_LDST, 5'd16, 32'h0000_1616);
    endtask

    task automatic test_flush();
        dispatch(FU_ALU, OP_ADD, 5'd17, 5'd16, 5'd0, '0, 1'b0, TAG_ON_LDST, TAG_NONE);
        dispatch(FU_BRANCH, OP_BEQ, 5'd0, 5'd17, 5'd5, '0, 1'b0, TAG_NONE, TAG_ON_LDST);
        check_fu_en("flush busy before", 3'b101, fust_busy);
        flush = 1'b1;
        tick();
        flush = 1'b0;
        check_fu_en("flush busy after", '0, fust_busy);
        // the producer finishing must not wake the dropped rows
        writeback(FU_LDST, 5'd18, 32'h0000_1818);
        repeat (4) begin
            tick();
            check_fu_en("flush no issue", '0, iss_fu_en);
        end
    endtask

    task automatic test_random();
        regsel_t               rd;
        regsel_t               rs1;
        regsel_t               rs2;
        logic [DATA_WIDTH-1:0] data;
        regsel_t               written [$];
        for (int i = 0; i < 8; i++) begin
            rd   = regsel_t'(rand_bits(5));
            data = rand_bits(32);
            written.push_back(rd);
            writeback(FU_BRANCH, rd, data);
        end
        for (int i = 0; i < 8; i++) begin
            rs1 = written[rand_bits(3)];
            rs2 = regsel_t'(rand_bits(5));
            rd  = regsel_t'(rand_bits(5));
            dispatch(FU_ALU, OP_AND, rd, rs1, rs2, '0, 1'b0, TAG_NONE, TAG_NONE);
            wait_issue("random issue", 3'b001);
            check_word("random rdat1", model_regs[rs1], iss_rdat1);
            check_word("random rdat2", model_regs[rs2], iss_rdat2);
            data = rand_bits(32);
            writeback(FU_ALU, rd, data);
        end
    endtask

    initial begin
        CLK         = 1'b0;
        nRST        = 1'b0;
        disp_en     = 1'b0;
        disp_fu     = FU_ALU;
        disp_op     = OP_ADD;
        disp_rd     = '0;
        disp_rs1    = '0;
        disp_rs2    = '0;
        disp_imm    = '0;
        disp_i_type = 1'b0;
        disp_t1     = TAG_NONE;
        disp_t2     = TAG_NONE;
        wb_en       = 1'b0;
        wb_fu       = FU_ALU;
        wb_rd       = '0;
        wb_data     = '0;
        freeze      = 1'b0;
        flush       = 1'b0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        lfsr_state  = 32'h3bcbd8ef;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge CLK);
        #1;
        nRST = 1'b1;
        tick();
        test_reset();
        test_immediate();
        test_dependence();
        test_oldest("oldest ldst", FU_LDST, OP_SW, FU_BRANCH, OP_BEQ);
        test_oldest("oldest branch", FU_BRANCH, OP_BNE, FU_LDST, OP_LW);
        test_freeze();
        test_flush();
        test_random();
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
common/issue_pkg.sv
src/regfile.sv
issue/fust_table.sv
issue/age_tracker.sv
issue/fust_sequencer.sv
issue/operand_latch.sv
issue/issue_stage.sv
test/issue_tb.sv
